//--- common/video_pkg.sv
`default_nettype none

package video_pkg;

    localparam int CHAN_W        = 4;          // bits per colour channel
    localparam int BLEND_LATENCY = 3;          // input to output, in clocks

    // one colour channel, also used for alpha and weights
    typedef logic [CHAN_W-1:0] chan_t;

    localparam chan_t CHAN_MAX = '1;           // full intensity / full weight

    // 12-bit rgb pixel, red in the top nibble
    typedef struct packed {
        chan_t r;                              // red
        chan_t g;                              // green
        chan_t b;                              // blue
    } rgb_t;

    // 16-bit argb pixel
    // layer B: alpha is the B alpha
    // layer A: alpha[3] forces A opaque, alpha[2] turns B off, [1:0] spare
    typedef struct packed {
        chan_t alpha;                          // alpha or layer-A flags
        rgb_t  rgb;                            // colour
    } argb_t;

    // raster timing carried next to each pixel
    typedef struct packed {
        logic de;                              // display enable
        logic hsync;                           // horizontal sync
        logic vsync;                           // vertical sync
    } vid_timing_t;

endpackage : video_pkg

`default_nettype wire

//--- common/blend_pkg.sv
`default_nettype none

package blend_pkg;

    import video_pkg::*;

    localparam int TERM_W = 7;                 // one scaled channel term
    localparam int SUM_W  = 8;                 // term sum, msb flags overflow

    // encoded as {a_opaque, b_off} straight from colour A bits 15:14
    typedef enum logic [1:0] {
        BLEND_ALPHA    = 2'b00,                // B alpha vs its complement
        BLEND_B_OFF    = 2'b01,                // A weighted, B dropped
        BLEND_A_OPAQUE = 2'b10,                // A full, B added on top
        BLEND_A_ONLY   = 2'b11                 // A full, B dropped
    } blend_mode_e;

    typedef logic [TERM_W-1:0] term_val_t;
    typedef logic [SUM_W-1:0]  sum_t;

    // three weighted channel terms of one layer
    typedef struct packed {
        term_val_t r;                          // red term
        term_val_t g;                          // green term
        term_val_t b;                          // blue term
    } rgb_term_t;

    // stage 1 register, 35 bits
    typedef struct packed {
        rgb_t        a_rgb;                    // layer A colour
        rgb_t        b_rgb;                    // layer B colour
        chan_t       a_weight;                 // weight applied to A
        chan_t       b_weight;                 // weight applied to B
        vid_timing_t timing;                   // syncs for this pixel
    } operand_t;

    // stage 2 register, 45 bits
    typedef struct packed {
        rgb_term_t   a_term;                   // scaled A channels
        rgb_term_t   b_term;                   // scaled B channels
        vid_timing_t timing;                   // syncs for this pixel
    } term_t;

endpackage : blend_pkg

`default_nettype wire

//--- blend/alpha_select.sv
`default_nettype none

module alpha_select (
    input  wire logic                  clk,
    input  wire logic                  rst_n_i,      // sync, active low
    input  wire video_pkg::argb_t      colour_a_i,   // layer A colour + flags
    input  wire video_pkg::argb_t      colour_b_i,   // layer B colour + alpha
    input  wire video_pkg::vid_timing_t timing_i,    // raster timing in
    output blend_pkg::operand_t        operand_o     // stage 1 register
);

    import video_pkg::*;
    import blend_pkg::*;

    blend_mode_e mode;                         // decoded layer-A flags
    chan_t       b_alpha;                      // layer B alpha
    chan_t       a_weight;                     // next A weight
    chan_t       b_weight;                     // next B weight
    operand_t    operand_d;                    // next stage 1 value

    assign b_alpha = colour_b_i.alpha;

    // flags sit in the top two bits of the A alpha field
    assign mode = blend_mode_e'(colour_a_i.alpha[3:2]);

    always_comb begin
        unique case (mode)
            BLEND_ALPHA: begin
                a_weight = ~b_alpha;           // 1 - alpha
                b_weight = b_alpha;
            end
            BLEND_A_OPAQUE: begin
                a_weight = CHAN_MAX;           // A at 100%
                b_weight = b_alpha;            // B still blended on top
            end
            BLEND_B_OFF: begin
                a_weight = ~b_alpha;
                b_weight = '0;                 // B suppressed
            end
            BLEND_A_ONLY: begin
                a_weight = CHAN_MAX;
                b_weight = '0;                 // A passes unchanged
            end
            default: begin
                a_weight = CHAN_MAX;
                b_weight = '0;
            end
        endcase
    end

    always_comb begin
        operand_d.a_rgb    = colour_a_i.rgb;
        operand_d.b_rgb    = colour_b_i.rgb;
        operand_d.a_weight = a_weight;
        operand_d.b_weight = b_weight;
        operand_d.timing   = timing_i;         // syncs ride with the pixel
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            operand_o <= '0;                   // syncs inactive, black
        end else begin
            operand_o <= operand_d;
        end
    end

endmodule : alpha_select

`default_nettype wire

//--- blend/channel_scale.sv
`default_nettype none

module channel_scale (
    input  wire logic                clk,
    input  wire logic                rst_n_i,    // sync, active low
    input  wire blend_pkg::operand_t operand_i,  // colours, weights, timing
    output blend_pkg::term_t         term_o      // stage 2 register
);

    import video_pkg::*;
    import blend_pkg::*;

    rgb_term_t a_term;                         // scaled A channels
    rgb_term_t b_term;                         // scaled B channels
    term_t     term_d;                         // next stage 2 value

    // one channel times one weight, result in 1/8 units of a channel step
    // full weight means exactly c, so take c*8 instead of c*15/2
    function automatic term_val_t scale_chan(chan_t c, chan_t w);
        logic [2*CHAN_W-1:0] prod;             // full 8-bit product
        term_val_t           term;
        prod = c * w;                          // inferred 4x4 multiply
        if (w == CHAN_MAX) begin
            term = {c, 3'b000};                // 100% alpha shortcut
        end else begin
            term = prod[2*CHAN_W-1:1];         // halve, round down
        end
        return term;
    endfunction

    // all three channels of a layer share one weight
    function automatic rgb_term_t scale_rgb(rgb_t c, chan_t w);
        rgb_term_t t;
        t.r = scale_chan(c.r, w);
        t.g = scale_chan(c.g, w);
        t.b = scale_chan(c.b, w);
        return t;
    endfunction

    assign a_term = scale_rgb(operand_i.a_rgb, operand_i.a_weight);
    assign b_term = scale_rgb(operand_i.b_rgb, operand_i.b_weight);

    always_comb begin
        term_d.a_term = a_term;
        term_d.b_term = b_term;
        term_d.timing = operand_i.timing;      // one more stage of sync delay
    end

    // products are registered here so stage 3 only adds
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            term_o <= '0;
        end else begin
            term_o <= term_d;
        end
    end

endmodule : channel_scale

`default_nettype wire

//--- blend/blend_mix.sv
`default_nettype none

module blend_mix (
    input  wire logic              clk,
    input  wire logic              rst_n_i,      // sync, active low
    input  wire blend_pkg::term_t  term_i,       // six terms + timing
    output video_pkg::rgb_t        blend_rgb_o,  // final pixel
    output video_pkg::vid_timing_t timing_o      // timing aligned to pixel
);

    import video_pkg::*;
    import blend_pkg::*;

    sum_t sum_r;                               // A + B red
    sum_t sum_g;                               // A + B green
    sum_t sum_b;                               // A + B blue
    rgb_t mix_rgb;                             // saturated mix

    // sum is in 1/8 steps; msb set means the channel ran past 15
    function automatic chan_t saturate(sum_t s);
        chan_t c;
        if (s[SUM_W-1]) begin
            c = CHAN_MAX;                      // clamp on overflow
        end else begin
            c = s[SUM_W-2 -: CHAN_W];          // drop 3 fraction bits
        end
        return c;
    endfunction

    assign sum_r = sum_t'(term_i.a_term.r) + sum_t'(term_i.b_term.r);
    assign sum_g = sum_t'(term_i.a_term.g) + sum_t'(term_i.b_term.g);
    assign sum_b = sum_t'(term_i.a_term.b) + sum_t'(term_i.b_term.b);

    always_comb begin
        mix_rgb.r = saturate(sum_r);
        mix_rgb.g = saturate(sum_g);
        mix_rgb.b = saturate(sum_b);
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            blend_rgb_o <= '0;                 // black
            timing_o    <= '0;                 // de and syncs low
        end else begin
            // blanking forces black, syncs pass either way
            blend_rgb_o <= term_i.timing.de ? mix_rgb : '0;
            timing_o    <= term_i.timing;
        end
    end

endmodule : blend_mix

`default_nettype wire

//--- verilog/video_blend_top.sv
`default_nettype none

// three-stage blender, every pixel and its syncs come out 3 clocks later
module video_blend_top (
    input  wire logic                   clk,
    input  wire logic                   rst_n_i,     // sync, active low
    input  wire video_pkg::argb_t       colour_a_i,  // layer A, flags in [15:14]
    input  wire video_pkg::argb_t       colour_b_i,  // layer B, alpha in [15:12]
    input  wire video_pkg::vid_timing_t timing_i,    // de, hsync, vsync
    output video_pkg::rgb_t             blend_rgb_o, // blended pixel
    output video_pkg::vid_timing_t      timing_o     // delayed timing
);

    import blend_pkg::*;

    operand_t operand;                         // stage 1 -> stage 2
    term_t    term;                            // stage 2 -> stage 3

    // stage 1: flag decode and weight select
    alpha_select i_alpha_select (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .colour_a_i (colour_a_i),
        .colour_b_i (colour_b_i),
        .timing_i   (timing_i),
        .operand_o  (operand)
    );

    // stage 2: per-channel multiply
    channel_scale i_channel_scale (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .operand_i (operand),
        .term_o    (term)
    );

    // stage 3: add, clamp, blank
    blend_mix i_blend_mix (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .term_i      (term),
        .blend_rgb_o (blend_rgb_o),
        .timing_o    (timing_o)
    );

endmodule : video_blend_top

`default_nettype wire

//--- verification/video_blend_checker.sv
`default_nettype none

module video_blend_checker (
    input wire logic                   clk,
    input wire logic                   rst_n_i,
    input wire video_pkg::argb_t       colour_a_i,
    input wire video_pkg::argb_t       colour_b_i,
    input wire video_pkg::vid_timing_t timing_i,
    input wire video_pkg::rgb_t        blend_rgb_o,
    input wire video_pkg::vid_timing_t timing_o
);

    import video_pkg::*;

    bit         fail_seen = 1'b0;              // polled by the testbench
    logic [1:0] edge_cnt  = 2'd0;              // clocks seen, saturates at 3
    logic       warm;                          // enough history for $past

    assign warm = (edge_cnt == 2'd3);

    always @(posedge clk) begin
        if (!warm) begin
            edge_cnt <= edge_cnt + 2'd1;
        end
    end

    // one layer's share of a channel, in eighths of a channel step
    function automatic int layer_share(int c, int w);
        if (w == 15) begin
            return c * 8;                      // full weight is exact
        end
        return (c * w) / 2;
    endfunction

    function automatic chan_t mix_chan(int ca, int cb, int wa, int wb);
        int s;
        s = layer_share(ca, wa) + layer_share(cb, wb);
        if (s >= 128) begin
            return CHAN_MAX;                   // clamp
        end
        return chan_t'(s / 8);
    endfunction

    // expected pixel for de high, straight from the layer-A flags
    function automatic rgb_t expected_rgb(argb_t a, argb_t b);
        int   wa;
        int   wb;
        rgb_t p;
        wa  = a.alpha[3] ? 15 : 15 - int'(b.alpha);   // opaque flag
        wb  = a.alpha[2] ? 0 : int'(b.alpha);         // B-off flag
        p.r = mix_chan(int'(a.rgb.r), int'(b.rgb.r), wa, wb);
        p.g = mix_chan(int'(a.rgb.g), int'(b.rgb.g), wa, wb);
        p.b = mix_chan(int'(a.rgb.b), int'(b.rgb.b), wa, wb);
        return p;
    endfunction

    // reset cleared some stage of the pipe within the last 3 clocks
    a_reset_timing: assert property (@(posedge clk)
        warm && (!$past(rst_n_i, 1) || !$past(rst_n_i, 2) || !$past(rst_n_i, 3))
        |-> timing_o == '0)
    else begin
        fail_seen = 1'b1;
        $error("ERROR t=%0t timing_o expected %h actual %h", $time, 3'h0, $sampled(timing_o));
    end

    a_reset_pixel: assert property (@(posedge clk)
        warm && (!$past(rst_n_i, 1) || !$past(rst_n_i, 2) || !$past(rst_n_i, 3))
        |-> blend_rgb_o == '0)
    else begin
        fail_seen = 1'b1;
        $error("ERROR t=%0t blend_rgb_o expected %h actual %h", $time, 12'h000,
               $sampled(blend_rgb_o));
    end

    a_timing_delay: assert property (@(posedge clk)
        warm && $past(rst_n_i, 1) && $past(rst_n_i, 2) && $past(rst_n_i, 3)
        |-> timing_o == $past(timing_i, BLEND_LATENCY))
    else begin
        fail_seen = 1'b1;
        $error("ERROR t=%0t timing_o expected %h actual %h", $time,
               $past(timing_i, BLEND_LATENCY), $sampled(timing_o));
    end

    a_blank: assert property (@(posedge clk)
        warm && $past(rst_n_i, 1) && $past(rst_n_i, 2) && $past(rst_n_i, 3)
        && !$past(timing_i.de, BLEND_LATENCY) |-> blend_rgb_o == '0)
    else begin
        fail_seen = 1'b1;
        $error("ERROR t=%0t blend_rgb_o expected %h actual %h", $time, 12'h000,
               $sampled(blend_rgb_o));
    end

    a_blend: assert property (@(posedge clk)
        warm && $past(rst_n_i, 1) && $past(rst_n_i, 2) && $past(rst_n_i, 3)
        && $past(timing_i.de, BLEND_LATENCY)
        |-> blend_rgb_o == expected_rgb($past(colour_a_i, BLEND_LATENCY),
                                        $past(colour_b_i, BLEND_LATENCY)))
    else begin
        fail_seen = 1'b1;
        $error("ERROR t=%0t blend_rgb_o expected %h actual %h", $time,
               expected_rgb($past(colour_a_i, BLEND_LATENCY),
                            $past(colour_b_i, BLEND_LATENCY)),
               $sampled(blend_rgb_o));
    end

endmodule : video_blend_checker

`default_nettype wire

//--- verification/video_blend_tb.sv
`default_nettype none

module video_blend_tb;

    import video_pkg::*;

    localparam int RESET_CYCLES  = 8;
    localparam int RANDOM_PIXELS = 400;
    localparam int RESET_LIMIT   = 4;          // clocks to see reset go high
    localparam int DRAIN_LIMIT   = 16;         // clocks for the marker to pop out

    logic        clk;
    logic        rst_n_i;
    argb_t       colour_a;
    argb_t       colour_b;
    vid_timing_t timing_in;
    rgb_t        blend_rgb;
    vid_timing_t timing_out;
    integer      seed;

    initial clk = 1'b0;
    always #5 clk = ~clk;                      // 10 time unit period

    video_blend_top i_dut (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .colour_a_i  (colour_a),
        .colour_b_i  (colour_b),
        .timing_i    (timing_in),
        .blend_rgb_o (blend_rgb),
        .timing_o    (timing_out)
    );

    bind video_blend_top video_blend_checker i_checker (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .colour_a_i  (colour_a_i),
        .colour_b_i  (colour_b_i),
        .timing_i    (timing_i),
        .blend_rgb_o (blend_rgb_o),
        .timing_o    (timing_o)
    );

    // stop at the first assertion that fires
    always @(negedge clk) begin
        if (i_dut.i_checker.fail_seen) begin
            $display("TEST FAIL");
            $fatal(1, "checker assertion failed");
        end
    end

    task automatic drive_pixel(input argb_t a, input argb_t b, input vid_timing_t t);
        @(negedge clk);
        colour_a  = a;
        colour_b  = b;
        timing_in = t;
    endtask

    task automatic wait_reset_release();
        int n;
        for (n = 0; n < RESET_LIMIT; n++) begin
            @(posedge clk);
            if (rst_n_i === 1'b1) begin
                return;
            end
        end
        $display("reset release not seen within %0d clocks", RESET_LIMIT);
        $display("TEST FAIL");
        $fatal(1, "reset wait timed out");
    endtask

    // every mode, alphas 0/7/15, corner colours, then blanked pixels
    task automatic directed_sweep();
        rgb_t        pats[4]   = '{12'h000, 12'hfff, 12'hf08, 12'h7a3};
        chan_t       alphas[3] = '{4'd0, 4'd7, 4'd15};
        argb_t       a;
        argb_t       b;
        vid_timing_t t;
        for (int m = 0; m < 4; m++) begin
            for (int ai = 0; ai < 3; ai++) begin
                for (int pa = 0; pa < 4; pa++) begin
                    for (int pb = 0; pb < 4; pb++) begin
                        a.alpha = {m[1:0], 2'b00};     // flags only
                        a.rgb   = pats[pa];
                        b.alpha = alphas[ai];
                        b.rgb   = pats[pb];
                        t       = '{de: 1'b1, hsync: pa[0], vsync: pb[0]};
                        drive_pixel(a, b, t);
                    end
                end
            end
            a = {m[1:0], 2'b01, 12'hfff};              // spare bit set too
            b = {4'd7, 12'hfff};
            t = '{de: 1'b0, hsync: 1'b1, vsync: m[0]};
            drive_pixel(a, b, t);
        end
    endtask

    task automatic random_pixels();
        logic [31:0] ra;
        logic [31:0] rb;
        logic [31:0] rt;
        repeat (RANDOM_PIXELS) begin
            ra = $random(seed);
            rb = $random(seed);
            rt = $random(seed);
            drive_pixel(ra[15:0], rb[15:0], rt[2:0]);
        end
    endtask

    // idle clocks flush the pipe, then a marker must reach the output
    task automatic drain_pipe();
        int n;
        repeat (BLEND_LATENCY) drive_pixel('0, '0, '0);
        drive_pixel('0, '0, 3'b111);
        drive_pixel('0, '0, '0);
        for (n = 0; n < DRAIN_LIMIT; n++) begin
            if (timing_out === 3'b111) begin
                @(negedge clk);                        // let its check run
                return;
            end
            @(negedge clk);
        end
        $display("pipeline did not drain within %0d clocks", DRAIN_LIMIT);
        $display("TEST FAIL");
        $fatal(1, "drain wait timed out");
    endtask

    initial begin
        seed      = 32'hc4a0;
        rst_n_i   = 1'b0;
        colour_a  = 16'h0fff;                  // lit pixel held through reset
        colour_b  = {4'd7, 12'hfff};
        timing_in = 3'b111;                    // de and both syncs active
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n_i = 1'b1;
        wait_reset_release();
        directed_sweep();
        random_pixels();
        drain_pipe();
        if (i_dut.i_checker.fail_seen) begin
            $display("TEST FAIL");
            $fatal(1, "checker assertion failed");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule : video_blend_tb

`default_nettype wire

//--- src.f
common/video_pkg.sv
common/blend_pkg.sv
blend/alpha_select.sv
blend/channel_scale.sv
blend/blend_mix.sv
verilog/video_blend_top.sv
verification/video_blend_checker.sv
verification/video_blend_tb.sv

//--- Bender.yml
package:
  name: video_blend

sources:
  # shared packages first
  - common/video_pkg.sv
  - common/blend_pkg.sv
  # blend pipeline stages
  - blend/alpha_select.sv
  - blend/channel_scale.sv
  - blend/blend_mix.sv
  # top level
  - verilog/video_blend_top.sv
  # verification
  - target: test
    files:
      - verification/video_blend_checker.sv
      - verification/video_blend_tb.sv
